// File: Bender.yml
package:
  name: intra4_encoder

sources:
  - verilog/pixel_pkg.sv
  - verilog/quant_pkg.sv
  - verilog/block_buffer.sv
  - verilog/mode_decision.sv
  - verilog/residual_quantizer.sv
  - verilog/intra4_encoder.sv
  - target: test
    files:
      - verification/intra4_encoder_assertions.sv
      - verification/intra4_encoder_tb.sv

// File: compile.f
verilog/pixel_pkg.sv
verilog/quant_pkg.sv
verilog/block_buffer.sv
verilog/mode_decision.sv
verilog/residual_quantizer.sv
verilog/intra4_encoder.sv
verification/intra4_encoder_assertions.sv
verification/intra4_encoder_tb.sv

// File: verification/intra4_encoder_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module intra4_encoder_assertions
    import pixel_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       out_valid,
    input pred_mode_t out_mode
);

    int error_count = 0;

    // ======================================================================
    // output protocol
    // ======================================================================

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            error_count++;
        end

    burst_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> out_valid [*16] ##1 !out_valid)
        else begin
            $error("out_valid burst not exactly 16 cycles");
            error_count++;
        end

    // mode held for the whole burst
    mode_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && $past(out_valid)) |-> $stable(out_mode))
        else begin
            $error("out_mode changed inside a burst");
            error_count++;
        end

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && out_valid))
        else begin
            $error("in_valid high while out_valid high");
            error_count++;
        end

endmodule

bind intra4_encoder intra4_encoder_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_mode  (out_mode)
);

`default_nettype wire

// File: verification/intra4_encoder_tb.sv
`timescale 1ns/1ns
`default_nettype none

module intra4_encoder_tb
    import pixel_pkg::*, quant_pkg::*;
();

    typedef pixel_t ref_t [4];
    typedef pixel_t blk_t [16];
    typedef coef_t  coef_blk_t [16];

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    pixel_t     in_pixel;
    qp_t        in_qp;
    logic       out_valid;
    coef_t      out_value;
    pred_mode_t out_mode;

    // stimulus of the block being sent
    ref_t   top_px;
    ref_t   left_px;
    blk_t   blk_px;
    qp_t    blk_qp;

    // expected results, oldest block first
    pred_mode_t mode_q [$];
    coef_t      coef_q [$];
    string      name_q [$];
    int         edge_q [$];

    int cycle_count = 0;

    intra4_encoder #(
        .SAD_W (12)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .in_qp     (in_qp),
        .out_valid (out_valid),
        .out_value (out_value),
        .out_mode  (out_mode)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic int abs_int(input int v);
        abs_int = (v < 0) ? -v : v;
    endfunction

    // rows of H are ++++ ++-- +--+ +-+-
    function automatic int hadamard_sign(input int row, input int col);
        case (row)
            0:       hadamard_sign = 1;
            1:       hadamard_sign = (col < 2) ? 1 : -1;
            2:       hadamard_sign = (col == 0 || col == 3) ? 1 : -1;
            default: hadamard_sign = (col % 2 == 0) ? 1 : -1;
        endcase
    endfunction

    function automatic int quant_mult(input int rem, input int pos);
        int row_a [6];
        int row_b [6];
        int row_c [6];
        row_a = '{13107, 11916, 10082, 9362, 8192, 7282};
        row_b = '{5243, 4660, 4194, 3647, 3355, 2893};
        row_c = '{8066, 7490, 6554, 5825, 5243, 4559};
        if (pos == 0 || pos == 2 || pos == 8 || pos == 10) begin
            quant_mult = row_a[rem];
        end else if (pos == 5 || pos == 7 || pos == 13 || pos == 15) begin
            quant_mult = row_b[rem];
        end else begin
            quant_mult = row_c[rem];
        end
    endfunction

    function automatic pred_mode_t model_block(input ref_t top, input ref_t left,
                                               input blk_t px, input qp_t qp,
                                               output coef_blk_t coefs);
        int dc;
        int sad_dc;
        int sad_hor;
        int sad_ver;
        int pred;
        int sum;
        int qbits;
        int z;
        int res [16];
        pred_mode_t mode;
        dc = 0;
        for (int i = 0; i < 4; i++) begin
            dc = dc + int'(top[i]) + int'(left[i]);
        end
        dc = dc / 8;
        sad_dc  = 0;
        sad_hor = 0;
        sad_ver = 0;
        for (int i = 0; i < 16; i++) begin
            sad_dc  = sad_dc + abs_int(int'(px[i]) - dc);
            sad_hor = sad_hor + abs_int(int'(px[i]) - int'(left[i / 4]));
            sad_ver = sad_ver + abs_int(int'(px[i]) - int'(top[i % 4]));
        end
        if (sad_ver >= sad_hor && sad_dc > sad_hor) begin
            mode = mode_horizontal;
        end else if (sad_hor > sad_ver && sad_dc > sad_ver) begin
            mode = mode_vertical;
        end else begin
            mode = mode_dc;
        end
        for (int i = 0; i < 16; i++) begin
            if (mode == mode_horizontal) begin
                pred = int'(left[i / 4]);
            end else if (mode == mode_vertical) begin
                pred = int'(top[i % 4]);
            end else begin
                pred = dc;
            end
            res[i] = int'(px[i]) - pred;
        end
        qbits = 15 + int'(qp) / 6;
        for (int k = 0; k < 16; k++) begin
            sum = 0;
            for (int i = 0; i < 16; i++) begin
                sum = sum + res[i] * hadamard_sign(k / 4, i / 4) * hadamard_sign(k % 4, i % 4);
            end
            z = (abs_int(sum) * quant_mult(int'(qp) % 6, k) + (1 << qbits) / 3) >> qbits;
            coefs[k] = (sum < 0) ? -z : z;
        end
        model_block = mode;
    endfunction

    // ======================================================================
    // checks
    // ======================================================================

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_mode(input string name, input pred_mode_t expected,
                              input pred_mode_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: %s mode expected %0d actual %0d",
                                        name, expected, actual));
        end
    endtask

    task automatic check_coef(input string name, input coef_t expected, input coef_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: %s expected %0d actual %0d",
                                        name, expected, actual));
        end
    endtask

    // outputs are sampled on the falling edge, away from the drive edge
    initial begin : compare_outputs
        int k;
        k = 0;
        forever begin
            @(negedge clk);
            if (uut.u_assertions.error_count != 0) begin
                stop_with_failure("protocol assertion failed on the DUT outputs");
            end
            if (out_valid) begin
                if (mode_q.size() == 0) begin
                    stop_with_failure("output burst seen with no block sent");
                end
                if (k == 0) begin
                    check_coef({name_q[0], " first coefficient edge"},
                               edge_q[0] + 2, cycle_count);
                end
                check_mode(name_q[0], mode_q[0], out_mode);
                check_coef($sformatf("%s coef %0d", name_q[0], k), coef_q.pop_front(),
                           out_value);
                k++;
                if (k == 16) begin
                    k = 0;
                    void'(mode_q.pop_front());
                    void'(name_q.pop_front());
                    void'(edge_q.pop_front());
                end
            end else if (k != 0) begin
                stop_with_failure("out_valid dropped in the middle of a burst");
            end
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    // returns on the edge after the last out_valid cycle
    task automatic wait_for_outputs(input string name);
        int waited;
        waited = 0;
        while (mode_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 40) begin
                stop_with_failure({name, ": no complete output burst within 40 cycles"});
            end
        end
    endtask

    // starts driving on the current rising edge
    task automatic send_block(input string name);
        pred_mode_t exp_mode;
        coef_blk_t  exp_coefs;
        exp_mode = model_block(top_px, left_px, blk_px, blk_qp, exp_coefs);
        mode_q.push_back(exp_mode);
        name_q.push_back(name);
        for (int k = 0; k < 16; k++) begin
            coef_q.push_back(exp_coefs[k]);
        end
        for (int b = 0; b < 24; b++) begin
            if (b != 0) begin
                @(posedge clk);
            end
            in_valid <= 1'b1;
            in_qp    <= blk_qp;
            in_pixel <= (b < 4) ? top_px[b] : (b < 8) ? left_px[b - 4] : blk_px[b - 8];
        end
        @(posedge clk);
        // this edge samples beat 23
        edge_q.push_back(cycle_count + 1);
        in_valid <= 1'b0;
        in_pixel <= '0;
        wait_for_outputs(name);
    endtask

    task automatic fill_random();
        for (int i = 0; i < 4; i++) begin
            top_px[i]  = pixel_t'($urandom % 256);
            left_px[i] = pixel_t'($urandom % 256);
        end
        for (int i = 0; i < 16; i++) begin
            blk_px[i] = pixel_t'($urandom % 256);
        end
    endtask

    initial begin : main_sequence
        qp_t sweep [6];
        int  x;
        int  y;
        sweep = '{5'd0, 5'd5, 5'd6, 5'd17, 5'd24, 5'd29};
        void'($urandom(8418));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pixel = '0;
        in_qp    = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // flat block, every sad equal
        x = $urandom % 256;
        top_px  = '{4{pixel_t'(x)}};
        left_px = '{4{pixel_t'(x)}};
        blk_px  = '{16{pixel_t'(x)}};
        blk_qp  = qp_t'($urandom % 30);
        send_block("flat");

        // rows copy the left column
        fill_random();
        for (int i = 0; i < 4; i++) begin
            left_px[i] = pixel_t'(20 + 60 * i + $urandom % 20);
        end
        for (int i = 0; i < 16; i++) begin
            blk_px[i] = left_px[i / 4];
        end
        send_block("row_constant");

        // columns copy the top row
        fill_random();
        for (int i = 0; i < 4; i++) begin
            top_px[i] = pixel_t'(20 + 60 * i + $urandom % 20);
        end
        for (int i = 0; i < 16; i++) begin
            blk_px[i] = top_px[i % 4];
        end
        send_block("column_constant");

        // symmetric block, horizontal and vertical sads tie
        x = $urandom % 90;
        y = x + 64 + $urandom % 100;
        top_px  = '{pixel_t'(x), pixel_t'(x), pixel_t'(y), pixel_t'(y)};
        left_px = top_px;
        for (int i = 0; i < 16; i++) begin
            blk_px[i] = (top_px[i / 4] < top_px[i % 4]) ? top_px[i / 4] : top_px[i % 4];
        end
        send_block("tie");

        fill_random();
        for (int i = 0; i < 6; i++) begin
            blk_qp = sweep[i];
            send_block($sformatf("qp_sweep qp %0d", sweep[i]));
        end

        for (int n = 0; n < 200; n++) begin
            fill_random();
            blk_qp = qp_t'($urandom % 30);
            send_block($sformatf("random block %0d", n));
        end

        // last burst ends on the edge before this one
        @(negedge clk);
        if (uut.u_assertions.error_count != 0) begin
            stop_with_failure("protocol assertion failed on the DUT outputs");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/block_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module block_buffer
    import pixel_pkg::*, quant_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  pixel_t in_pixel,
    input  qp_t    in_qp,
    output beat_t  beat,
    output pixel_t block_pixels [0:BLOCK_PIXELS-1],
    output qp_t    qp,
    output logic   block_done
);

    logic       last_beat;
    logic [3:0] pix_idx;

    assign last_beat = (beat == beat_t'(REF_BEATS + BLOCK_PIXELS - 1));
    // raster position of the current block pixel
    assign pix_idx = 4'(beat - beat_t'(REF_BEATS));

    // shared beat counter, wraps after the last pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat       <= '0;
            block_done <= 1'b0;
        end else begin
            block_done <= in_valid && last_beat;
            if (in_valid) begin
                beat <= last_beat ? '0 : beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && beat == '0) begin
            qp <= in_qp;
        end
        if (in_valid && beat >= beat_t'(REF_BEATS)) begin
            block_pixels[pix_idx] <= in_pixel;
        end
    end

endmodule

`default_nettype wire

// File: verilog/intra4_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module intra4_encoder
    import pixel_pkg::*, quant_pkg::*;
#(
    parameter int SAD_W = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  pixel_t     in_pixel,
    input  qp_t        in_qp,
    output logic       out_valid,
    output coef_t      out_value,
    output pred_mode_t out_mode
);

    // block store to the other two units
    beat_t      beat;
    pixel_t     block_pixels [0:BLOCK_PIXELS-1];
    qp_t        qp;
    logic       block_done;

    // mode decision results
    pred_mode_t best_mode;
    pixel_t     dc_pred;
    pixel_t     top_ref  [0:3];
    pixel_t     left_ref [0:3];

    block_buffer u_block_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pixel     (in_pixel),
        .in_qp        (in_qp),
        .beat         (beat),
        .block_pixels (block_pixels),
        .qp           (qp),
        .block_done   (block_done)
    );

    mode_decision #(
        .SAD_W (SAD_W)
    ) u_mode_decision (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .beat      (beat),
        .best_mode (best_mode),
        .dc_pred   (dc_pred),
        .top_ref   (top_ref),
        .left_ref  (left_ref)
    );

    residual_quantizer u_residual_quantizer (
        .clk          (clk),
        .rst_n        (rst_n),
        .block_done   (block_done),
        .block_pixels (block_pixels),
        .qp           (qp),
        .best_mode    (best_mode),
        .dc_pred      (dc_pred),
        .top_ref      (top_ref),
        .left_ref     (left_ref),
        .out_valid    (out_valid),
        .out_value    (out_value),
        .out_mode     (out_mode)
    );

endmodule

`default_nettype wire

// File: verilog/mode_decision.sv
`timescale 1ns/1ns
`default_nettype none

module mode_decision
    import pixel_pkg::*;
#(
    parameter int SAD_W = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  pixel_t     in_pixel,
    input  beat_t      beat,
    output pred_mode_t best_mode,
    output pixel_t     dc_pred,
    output pixel_t     top_ref  [0:3],
    output pixel_t     left_ref [0:3]
);

    logic [10:0]      ref_sum;
    logic [3:0]       pix_idx;
    logic [SAD_W-1:0] sad_dc;
    logic [SAD_W-1:0] sad_hor;
    logic [SAD_W-1:0] sad_ver;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        abs_diff = (a > b) ? a - b : b - a;
    endfunction

    // ======================================================================
    // reference capture and dc value
    // ======================================================================

    always_ff @(posedge clk) begin
        if (in_valid && beat < beat_t'(4)) begin
            top_ref[beat[1:0]] <= in_pixel;
        end else if (in_valid && beat < beat_t'(REF_BEATS)) begin
            left_ref[beat[1:0]] <= in_pixel;
        end
    end

    always_comb begin
        ref_sum = '0;
        for (int i = 0; i < 4; i++) begin
            ref_sum = ref_sum + top_ref[i] + left_ref[i];
        end
    end

    assign dc_pred = pixel_t'(ref_sum >> 3);

    // ======================================================================
    // sad accumulation over the block pixels
    // ======================================================================

    // row in bits 3:2, column in bits 1:0
    assign pix_idx = 4'(beat - beat_t'(REF_BEATS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sad_dc  <= '0;
            sad_hor <= '0;
            sad_ver <= '0;
        end else if (in_valid && beat == '0) begin
            sad_dc  <= '0;
            sad_hor <= '0;
            sad_ver <= '0;
        end else if (in_valid && beat >= beat_t'(REF_BEATS)) begin
            sad_dc  <= sad_dc + SAD_W'(abs_diff(in_pixel, dc_pred));
            sad_hor <= sad_hor + SAD_W'(abs_diff(in_pixel, left_ref[pix_idx[3:2]]));
            sad_ver <= sad_ver + SAD_W'(abs_diff(in_pixel, top_ref[pix_idx[1:0]]));
        end
    end

    // horizontal wins a tie with vertical, dc wins any tie with the winner
    always_comb begin
        if (sad_ver >= sad_hor && sad_dc > sad_hor) begin
            best_mode = mode_horizontal;
        end else if (sad_hor > sad_ver && sad_dc > sad_ver) begin
            best_mode = mode_vertical;
        end else begin
            best_mode = mode_dc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pixel_pkg.sv
`default_nettype none

// block geometry and the sample types shared by the encoder units
package pixel_pkg;

    // ======================================================================
    // samples and beats
    // ======================================================================

    // unsigned luma sample
    typedef logic [7:0] pixel_t;

    // input beat index, 0..23 within one block
    typedef logic [4:0] beat_t;

    // samples in one 4x4 block
    localparam int BLOCK_PIXELS = 16;

    // top row then left column, ahead of the block pixels
    localparam int REF_BEATS = 8;

    // ======================================================================
    // intra 4x4 prediction modes
    // ======================================================================

    typedef enum logic [1:0] {
        mode_dc,
        mode_horizontal,
        mode_vertical
    } pred_mode_t;

endpackage

`default_nettype wire

// File: verilog/quant_pkg.sv
`default_nettype none

// quantiser types and the forward quantisation tables
package quant_pkg;

    typedef logic [4:0] qp_t;
    typedef logic signed [31:0] coef_t;
    // pixel minus prediction, -255..255
    typedef logic signed [8:0] residual_t;

    // ======================================================================
    // quantisation tables
    // ======================================================================

    // multiplier per qp%6 row and coefficient position class
    function automatic logic [13:0] mult_factor(input logic [2:0] qp_rem,
                                                input logic [3:0] pos);
        logic [13:0] class_a;
        logic [13:0] class_b;
        logic [13:0] class_c;
        case (qp_rem)
            3'd0:    {class_a, class_b, class_c} = {14'd13107, 14'd5243, 14'd8066};
            3'd1:    {class_a, class_b, class_c} = {14'd11916, 14'd4660, 14'd7490};
            3'd2:    {class_a, class_b, class_c} = {14'd10082, 14'd4194, 14'd6554};
            3'd3:    {class_a, class_b, class_c} = {14'd9362, 14'd3647, 14'd5825};
            3'd4:    {class_a, class_b, class_c} = {14'd8192, 14'd3355, 14'd5243};
            default: {class_a, class_b, class_c} = {14'd7282, 14'd2893, 14'd4559};
        endcase
        case (pos)
            4'd0, 4'd2, 4'd8, 4'd10:  mult_factor = class_a;
            4'd5, 4'd7, 4'd13, 4'd15: mult_factor = class_b;
            default:                  mult_factor = class_c;
        endcase
    endfunction

    // 15..19 for qp 0..29
    function automatic logic [4:0] quant_bits(input qp_t qp);
        quant_bits = 5'(15 + qp / 6);
    endfunction

    // 2^qbits / 3, truncated
    function automatic logic [17:0] rounding_offset(input qp_t qp);
        rounding_offset = 18'((32'd1 << quant_bits(qp)) / 3);
    endfunction

endpackage

`default_nettype wire

// File: verilog/residual_quantizer.sv
`timescale 1ns/1ns
`default_nettype none

module residual_quantizer
    import pixel_pkg::*, quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       block_done,
    input  pixel_t     block_pixels [0:BLOCK_PIXELS-1],
    input  qp_t        qp,
    input  pred_mode_t best_mode,
    input  pixel_t     dc_pred,
    input  pixel_t     top_ref  [0:3],
    input  pixel_t     left_ref [0:3],
    output logic       out_valid,
    output coef_t      out_value,
    output pred_mode_t out_mode
);

    pixel_t            pred     [0:BLOCK_PIXELS-1];
    residual_t         res_next [0:BLOCK_PIXELS-1];
    residual_t         res      [0:BLOCK_PIXELS-1];
    qp_t               qp_q;
    logic              active;
    logic [3:0]        k;
    logic signed [12:0] coef_sum;
    logic [12:0]       coef_mag;
    logic [2:0]        qp_rem;
    logic [31:0]       scaled;
    logic [31:0]       z_mag;
    coef_t             q_value;

    // minus entries of H, rows ++++ ++-- +--+ +-+-
    function automatic logic h_neg(input logic [1:0] row, input logic [1:0] col);
        case (row)
            2'd0:    h_neg = 1'b0;
            2'd1:    h_neg = col[1];
            2'd2:    h_neg = col[1] ^ col[0];
            default: h_neg = col[0];
        endcase
    endfunction

    // ======================================================================
    // residual against the chosen prediction
    // ======================================================================

    always_comb begin
        for (int i = 0; i < BLOCK_PIXELS; i++) begin
            case (best_mode)
                mode_horizontal: pred[i] = left_ref[i / 4];
                mode_vertical:   pred[i] = top_ref[i % 4];
                default:         pred[i] = dc_pred;
            endcase
            res_next[i] = residual_t'({1'b0, block_pixels[i]}) - residual_t'({1'b0, pred[i]});
        end
    end

    always_ff @(posedge clk) begin
        if (block_done) begin
            res  <= res_next;
            qp_q <= qp;
        end
    end

    // ======================================================================
    // coefficient k = 4a + b and its quantisation
    // ======================================================================

    always_comb begin
        coef_sum = '0;
        for (int i = 0; i < BLOCK_PIXELS; i++) begin
            if (h_neg(k[3:2], 2'(i / 4)) ^ h_neg(k[1:0], 2'(i % 4))) begin
                coef_sum = coef_sum - res[i];
            end else begin
                coef_sum = coef_sum + res[i];
            end
        end
    end

    assign coef_mag = coef_sum[12] ? 13'(-coef_sum) : 13'(coef_sum);
    assign qp_rem   = 3'(qp_q % 6);
    assign scaled   = coef_mag * mult_factor(qp_rem, k) + rounding_offset(qp_q);
    assign z_mag    = scaled >> quant_bits(qp_q);
    // sign of the transform output goes back on
    assign q_value  = coef_sum[12] ? -coef_t'(z_mag) : coef_t'(z_mag);

    // one coefficient per cycle, 16 in a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            k         <= '0;
            out_valid <= 1'b0;
            out_value <= '0;
            out_mode  <= mode_dc;
        end else begin
            out_valid <= active;
            out_value <= active ? q_value : '0;
            if (block_done) begin
                active   <= 1'b1;
                k        <= '0;
                out_mode <= best_mode;
            end else if (active) begin
                k <= k + 1'b1;
                if (k == 4'd15) begin
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire
